// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= aluCore_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test completed successfully

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run and check $(LOG)"
	@echo "make clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== include/alu_config.svh ====
/* Widths and APB address map of the execute unit. The decoder assumes RV32, so DATA_WIDTH
   stays at 32. Register n is read at REG_BASE + 4*n. */
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

`define DATA_WIDTH      32
`define REG_COUNT       32
`define REG_IDX_WIDTH   $clog2(`REG_COUNT)

`define APB_ADDR_WIDTH  12

// write-only issue register
`define INSTR_ADDR      12'h000
// register file window, word aligned, read only
`define REG_BASE        12'h100

`endif

// ==== source/alu.sv ====
/* Combinational RV32I ALU. Shift amounts use the low bits of b only. */
`timescale 1ns/1ps
`include "alu_config.svh"

module alu (
    input  logic [`DATA_WIDTH-1:0] a,
    input  logic [`DATA_WIDTH-1:0] b,
    input  aluPkg::aluOp_t         op,
    output logic [`DATA_WIDTH-1:0] result
);
    import aluPkg::*;

    localparam int SHAMT_WIDTH = $clog2(`DATA_WIDTH);

    logic [SHAMT_WIDTH-1:0] shamt;
    logic lessSigned;
    logic lessUnsigned;

    assign shamt        = b[SHAMT_WIDTH-1:0];
    assign lessSigned   = $signed(a) < $signed(b);
    assign lessUnsigned = a < b;

    always_comb begin
        case (op)
            ADD:     result = a + b;
            SUB:     result = a - b;
            SLT:     result = {{(`DATA_WIDTH-1){1'b0}}, lessSigned};
            SLTU:    result = {{(`DATA_WIDTH-1){1'b0}}, lessUnsigned};
            SLL:     result = a << shamt;
            SRL:     result = a >> shamt;
            SRA:     result = $unsigned($signed(a) >>> shamt); // keeps sign bit
            AND:     result = a & b;
            OR:      result = a | b;
            XOR:     result = a ^ b;
            default: result = a + b;
        endcase
    end

endmodule

// ==== source/aluControl.sv ====
/* Maps class, funct7 and funct3 to an ALU op. I-type funct3 1, 3, 5 and unknown R-type
   funct7 values fall back to ADD. */
`timescale 1ns/1ps

module aluControl (
    input  rvIsaPkg::insType_t insType,
    input  rvIsaPkg::funct7_t  funct7,
    input  rvIsaPkg::funct3_t  funct3,
    output aluPkg::aluOp_t     opSel
);
    import rvIsaPkg::*;
    import aluPkg::*;

    always_comb begin : opSelDecode
        opSel = ADD;
        case (insType)
            I_TYPE: begin
                case (funct3)
                    ADD_SUB:       opSel = ADD;
                    rvIsaPkg::SLT: opSel = aluPkg::SLT;
                    LXOR:          opSel = XOR;
                    LOR:           opSel = OR;
                    LAND:          opSel = AND;
                    default:       opSel = ADD; // no SLTIU, no imm shifts
                endcase
            end
            R_TYPE: begin
                case (funct7)
                    BASE: begin
                        case (funct3)
                            ADD_SUB:        opSel = ADD;
                            rvIsaPkg::SLL:  opSel = aluPkg::SLL;
                            rvIsaPkg::SLT:  opSel = aluPkg::SLT;
                            rvIsaPkg::SLTU: opSel = aluPkg::SLTU;
                            LXOR:           opSel = XOR;
                            SRL_SRA:        opSel = SRL;
                            LOR:            opSel = OR;
                            LAND:           opSel = AND;
                            default:        opSel = ADD;
                        endcase
                    end
                    ALT: begin
                        case (funct3)
                            ADD_SUB: opSel = SUB;
                            SRL_SRA: opSel = SRA;
                            default: opSel = ADD;
                        endcase
                    end
                    default: opSel = ADD;
                endcase
            end
            U_TYPE:  opSel = ADD; // ADD with rs1 at x0 passes imm
            default: opSel = ADD;
        endcase
    end

endmodule

// ==== source/aluCore.sv ====
/* Single-issue RV32I execute unit behind APB. Supports OP, OP-IMM and LUI, one instruction
   in flight, result written one cycle after the issuing write. */
`timescale 1ns/1ps
`include "alu_config.svh"

module aluCore (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [`APB_ADDR_WIDTH-1:0]  paddr,
    input  logic [`DATA_WIDTH-1:0]      pwdata,
    output logic [`DATA_WIDTH-1:0]      prdata,
    output logic                        pready,
    output logic                        pslverr
);
    import rvIsaPkg::*;
    import aluPkg::*;

    logic [`DATA_WIDTH-1:0]    instrWord;
    logic                      issue;
    logic                      illegal;
    logic                      execBusy;
    insType_t                  insType;
    funct7_t                   funct7;
    funct3_t                   funct3;
    aluOp_t                    opSel;
    aluOp_t                    execOp;
    logic [`REG_IDX_WIDTH-1:0] rs1Addr;
    logic [`REG_IDX_WIDTH-1:0] rs2Addr;
    logic [`REG_IDX_WIDTH-1:0] rdAddr;
    logic [`REG_IDX_WIDTH-1:0] hostAddr;
    logic [`DATA_WIDTH-1:0]    imm;
    logic                      useImm;
    logic [`DATA_WIDTH-1:0]    rs1Data;
    logic [`DATA_WIDTH-1:0]    rs2Data;
    logic [`DATA_WIDTH-1:0]    hostData;
    logic [`DATA_WIDTH-1:0]    operandB;
    logic [`DATA_WIDTH-1:0]    result;

    assign operandB = useImm ? imm : rs2Data; // I-type and LUI take imm

    hostPort uHostPort (
        .clk(clk), .rstN(rstN),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .illegal(illegal), .execBusy(execBusy),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .instrWord(instrWord), .issue(issue), .hostAddr(hostAddr), .hostData(hostData)
    );

    instrDecode uDecode (
        .clk(clk), .rstN(rstN), .instrWord(instrWord), .issue(issue), .opSel(opSel),
        .illegal(illegal), .insType(insType), .funct7(funct7), .funct3(funct3),
        .execBusy(execBusy), .rs1Addr(rs1Addr), .rs2Addr(rs2Addr), .rdAddr(rdAddr),
        .imm(imm), .useImm(useImm), .execOp(execOp)
    );

    aluControl uAluControl (.insType(insType), .funct7(funct7), .funct3(funct3), .opSel(opSel));

    regFile uRegFile (
        .clk(clk), .rstN(rstN),
        .rs1Addr(rs1Addr), .rs2Addr(rs2Addr), .hostAddr(hostAddr),
        .rs1Data(rs1Data), .rs2Data(rs2Data), .hostData(hostData),
        .we(execBusy), .rdAddr(rdAddr), .wData(result)
    );

    alu uAlu (.a(rs1Data), .b(operandB), .op(execOp), .result(result));

endmodule

// ==== source/aluPkg.sv ====
/* ALU operation codes. ADD must stay at 0, LUI relies on it. */
package aluPkg;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        AND,
        OR,
        XOR
    } aluOp_t;

endpackage

// ==== source/hostPort.sv ====
/* APB slave. An access phase overlapping the execute cycle, or following a setup phase that
   did, waits one cycle. Unaligned register addresses count as unmapped. */
`timescale 1ns/1ps
`include "alu_config.svh"

module hostPort (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [`APB_ADDR_WIDTH-1:0]  paddr,
    input  logic [`DATA_WIDTH-1:0]      pwdata,
    input  logic                        illegal,
    input  logic                        execBusy,
    output logic [`DATA_WIDTH-1:0]      prdata,
    output logic                        pready,
    output logic                        pslverr,
    output logic [`DATA_WIDTH-1:0]      instrWord,
    output logic                        issue,
    output logic [`REG_IDX_WIDTH-1:0]   hostAddr,
    input  logic [`DATA_WIDTH-1:0]      hostData
);
    localparam logic [`APB_ADDR_WIDTH-1:0] REG_SPAN = `APB_ADDR_WIDTH'(4 * `REG_COUNT);

    logic setupPhase;
    logic accessPhase;
    logic waitReg;
    logic instrHit;
    logic regHit;
    logic accessErr;
    logic [`APB_ADDR_WIDTH-1:0] regOffset;

    assign setupPhase  = psel && !penable;
    assign accessPhase = psel && penable;

    // setup seen during execute, so the first access cycle waits
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            waitReg <= 1'b0;
        end else begin
            waitReg <= setupPhase && execBusy;
        end
    end

    assign regOffset = paddr - `REG_BASE;
    assign instrHit  = (paddr == `INSTR_ADDR);
    assign regHit    = (paddr >= `REG_BASE) && (regOffset < REG_SPAN) && (paddr[1:0] == 2'b00);
    assign hostAddr  = regOffset[`REG_IDX_WIDTH+1:2];

    always_comb begin
        accessErr = 1'b0;
        if (!instrHit && !regHit) begin
            accessErr = 1'b1; // unmapped
        end else if (pwrite && regHit) begin
            accessErr = 1'b1; // registers are read only
        end else if (!pwrite && instrHit) begin
            accessErr = 1'b1; // issue reg is write only
        end else if (pwrite && instrHit && illegal) begin
            accessErr = 1'b1;
        end
    end

    assign pready    = accessPhase && !execBusy && !waitReg;
    assign pslverr   = pready && accessErr;
    assign issue     = pready && pwrite && instrHit && !illegal;
    assign instrWord = pwdata;
    assign prdata    = (pready && !pwrite && regHit) ? hostData : '0;

endmodule

// ==== source/instrDecode.sv ====
/* Decodes OP, OP-IMM and LUI only, anything else is flagged illegal. The execute stage
   holds one instruction for exactly one cycle after issue. */
`timescale 1ns/1ps
`include "alu_config.svh"

module instrDecode (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic [`DATA_WIDTH-1:0]      instrWord,
    input  logic                        issue,
    input  aluPkg::aluOp_t              opSel,
    output logic                        illegal,
    output rvIsaPkg::insType_t          insType,
    output rvIsaPkg::funct7_t           funct7,
    output rvIsaPkg::funct3_t           funct3,
    output logic                        execBusy,
    output logic [`REG_IDX_WIDTH-1:0]   rs1Addr,
    output logic [`REG_IDX_WIDTH-1:0]   rs2Addr,
    output logic [`REG_IDX_WIDTH-1:0]   rdAddr,
    output logic [`DATA_WIDTH-1:0]      imm,
    output logic                        useImm,
    output aluPkg::aluOp_t              execOp
);
    import rvIsaPkg::*;

    opcode_t opcode;
    logic [`DATA_WIDTH-1:0] iImm;
    logic [`DATA_WIDTH-1:0] uImm;

    assign opcode = opcode_t'(instrWord[6:0]);
    assign funct7 = funct7_t'(instrWord[31:25]);
    assign funct3 = funct3_t'(instrWord[14:12]);

    always_comb begin
        case (opcode)
            OP_REG:  insType = R_TYPE;
            OP_IMM:  insType = I_TYPE;
            OP_LUI:  insType = U_TYPE;
            default: insType = NO_OP;
        endcase
    end

    assign illegal = (insType == NO_OP);

    assign iImm = {{(`DATA_WIDTH-12){instrWord[31]}}, instrWord[31:20]}; // sign extended
    assign uImm = {instrWord[31:12], 12'b0};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            execBusy <= 1'b0;
        end else begin
            execBusy <= issue; // one cycle in execute
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            rs1Addr <= (insType == U_TYPE) ? '0 : instrWord[19:15]; // LUI adds to x0
            rs2Addr <= instrWord[24:20];
            rdAddr  <= instrWord[11:7];
            imm     <= (insType == U_TYPE) ? uImm : iImm;
            useImm  <= (insType != R_TYPE);
            execOp  <= opSel;
        end
    end

endmodule

// ==== source/regFile.sv ====
/* 32 registers, x0 reads as zero and ignores writes. All reads are combinational. */
`timescale 1ns/1ps
`include "alu_config.svh"

module regFile (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic [`REG_IDX_WIDTH-1:0]   rs1Addr,
    input  logic [`REG_IDX_WIDTH-1:0]   rs2Addr,
    input  logic [`REG_IDX_WIDTH-1:0]   hostAddr,
    output logic [`DATA_WIDTH-1:0]      rs1Data,
    output logic [`DATA_WIDTH-1:0]      rs2Data,
    output logic [`DATA_WIDTH-1:0]      hostData,
    input  logic                        we,
    input  logic [`REG_IDX_WIDTH-1:0]   rdAddr,
    input  logic [`DATA_WIDTH-1:0]      wData
);
    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rdAddr != '0) begin
            regs[rdAddr] <= wData;
        end
    end

    assign rs1Data  = regs[rs1Addr];
    assign rs2Data  = regs[rs2Addr];
    assign hostData = regs[hostAddr];

endmodule

// ==== source/rvIsaPkg.sv ====
/* RV32I encoding fields. Only the OP, OP-IMM and LUI opcodes are named here. */
package rvIsaPkg;

    typedef enum logic [6:0] {
        OP_REG = 7'b0110011,
        OP_IMM = 7'b0010011,
        OP_LUI = 7'b0110111
    } opcode_t;

    typedef enum logic [1:0] {
        I_TYPE = 2'b11,
        R_TYPE = 2'b10,
        U_TYPE = 2'b01,
        NO_OP  = 2'b00
    } insType_t;

    typedef enum logic [2:0] { // instr[14:12]
        ADD_SUB = 3'd0,
        SLL     = 3'd1,
        SLT     = 3'd2,
        SLTU    = 3'd3,
        LXOR    = 3'd4,
        SRL_SRA = 3'd5,
        LOR     = 3'd6,
        LAND    = 3'd7
    } funct3_t;

    typedef enum logic [6:0] { // instr[31:25]
        BASE = 7'd0,
        ALT  = 7'd32
    } funct7_t;

endpackage

// ==== tb.f ====
+incdir+include
source/rvIsaPkg.sv
source/aluPkg.sv
source/aluControl.sv
source/instrDecode.sv
source/alu.sv
source/regFile.sv
source/hostPort.sv
source/aluCore.sv
tests/tbClock.sv
tests/aluCore_tb.sv

// ==== tests/aluCore_tb.sv ====
/* Directed APB tests of aluCore against a register model. Stops at the first mismatch,
   random data comes from a fixed seed. */
`timescale 1ns/1ps
`include "alu_config.svh"

module aluCore_tb;
    logic clk;
    logic rstN;
    logic psel;
    logic penable;
    logic pwrite;
    logic [`APB_ADDR_WIDTH-1:0] paddr;
    logic [`DATA_WIDTH-1:0] pwdata;
    logic [`DATA_WIDTH-1:0] prdata;
    logic pready;
    logic pslverr;
    logic [`DATA_WIDTH-1:0] regModel [32];
    integer seed;

    tbClock clockGen (.clk(clk), .rstN(rstN));

    aluCore dut (
        .clk(clk), .rstN(rstN), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    task automatic stopWithError(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else
            stopWithError($sformatf("ERR at %0t: %s expected %h, got %h",
                                    $time, name, expected, actual));
    endtask

    // expected result straight from the RV32I rules, with the ADD fallbacks
    function automatic logic [31:0] refResult(input logic [31:0] instr,
                                              input logic [31:0] s1, input logic [31:0] s2);
        logic [2:0] f3;
        logic [6:0] f7;
        logic [31:0] immI;
        logic [31:0] res;
        f3 = instr[14:12];
        f7 = instr[31:25];
        immI = {{20{instr[31]}}, instr[31:20]};
        res = s1 + s2;
        if (instr[6:0] == 7'b0110111) begin
            res = {instr[31:12], 12'b0};
        end else if (instr[6:0] == 7'b0010011) begin
            case (f3)
                3'd2: res = ($signed(s1) < $signed(immI)) ? 32'd1 : 32'd0;
                3'd4: res = s1 ^ immI;
                3'd6: res = s1 | immI;
                3'd7: res = s1 & immI;
                default: res = s1 + immI; // funct3 1, 3, 5 too
            endcase
        end else if (f7 == 7'd0) begin
            case (f3)
                3'd1: res = s1 << s2[4:0];
                3'd2: res = ($signed(s1) < $signed(s2)) ? 32'd1 : 32'd0;
                3'd3: res = (s1 < s2) ? 32'd1 : 32'd0;
                3'd4: res = s1 ^ s2;
                3'd5: res = s1 >> s2[4:0];
                3'd6: res = s1 | s2;
                3'd7: res = s1 & s2;
                default: res = s1 + s2;
            endcase
        end else if (f7 == 7'd32 && f3 == 3'd0) begin
            res = s1 - s2;
        end else if (f7 == 7'd32 && f3 == 3'd5) begin
            res = $unsigned($signed(s1) >>> s2[4:0]);
        end
        return res;
    endfunction

    task automatic apbAccess(input logic write, input logic [11:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output int waits, output logic err);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = wdata;
        @(posedge clk);
        #1 penable = 1'b1;
        waits = 0;
        @(negedge clk);
        while (!pready) begin
            waits++;
            assert (waits < 20) else stopWithError("pready never came within 20 cycles");
            @(negedge clk);
        end
        rdata = prdata;
        err = pslverr;
        @(posedge clk);
        #1 psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic idleCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic sendInstr(input logic [31:0] instr, output int waits);
        logic [31:0] expected;
        logic [31:0] rdata;
        logic err;
        expected = refResult(instr, regModel[instr[19:15]], regModel[instr[24:20]]);
        apbAccess(1'b1, `INSTR_ADDR, instr, rdata, waits, err);
        checkValue("pslverr", 32'd0, {31'd0, err});
        if (instr[11:7] != 5'd0)
            regModel[instr[11:7]] = expected;
    endtask

    task automatic issueInstr(input logic [31:0] instr);
        int waits;
        sendInstr(instr, waits);
        checkValue("write wait states", 32'd0, waits);
        idleCycle();
    endtask

    task automatic checkReg(input int idx, input int expWaits);
        logic [31:0] rdata;
        int waits;
        logic err;
        apbAccess(1'b0, `APB_ADDR_WIDTH'(`REG_BASE + 4 * idx), '0, rdata, waits, err);
        checkValue("pslverr", 32'd0, {31'd0, err});
        checkValue("read wait states", expWaits, waits);
        checkValue($sformatf("x%0d", idx), regModel[idx], rdata);
    endtask

    task automatic checkAll();
        for (int i = 0; i < 32; i++) begin
            checkReg(i, 0);
        end
    endtask

    task automatic expectError(input logic write, input logic [11:0] addr,
                               input logic [31:0] wdata, input string what);
        logic [31:0] rdata;
        int waits;
        logic err;
        apbAccess(write, addr, wdata, rdata, waits, err);
        assert (err) else stopWithError($sformatf("no pslverr for %s", what));
        idleCycle();
    endtask

    task automatic testResetAndLui();
        logic [31:0] r;
        checkAll();
        for (int i = 0; i < 32; i++) begin // i = 0 hits x0
            r = $random(seed);
            issueInstr({r[19:0], 5'(i), 7'b0110111});
        end
        checkAll();
    endtask

    task automatic testRType();
        logic [31:0] r;
        logic [4:0] rd;
        logic [2:0] f3;
        logic [6:0] f7;
        issueInstr({20'h80001, 5'd1, 7'b0110111}); // x1 negative
        issueInstr({20'h00003, 5'd2, 7'b0110111});
        for (int i = 1; i < 32; i++) begin
            r = $random(seed);
            issueInstr({r[11:0], 5'(i), 3'd0, 5'(i), 7'b0010011}); // low bits for shifts
        end
        for (int round = 0; round < 4; round++) begin
            for (int k = 0; k < 10; k++) begin
                r = $random(seed);
                f3 = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);
                f7 = (k < 8) ? 7'd0 : 7'd32;
                rd = (r[14:10] < 5'd3) ? 5'd3 : r[14:10];
                issueInstr({f7, (round == 0) ? 5'd2 : r[9:5], (round < 2) ? 5'd1 : r[4:0],
                            f3, rd, 7'b0110011});
                checkReg(int'(rd), 0);
            end
        end
    endtask

    task automatic testIType();
        logic [31:0] r;
        logic [4:0] rd;
        for (int k = 0; k < 16; k++) begin
            r = $random(seed);
            rd = (r[14:10] == 5'd0) ? 5'd31 : r[14:10];
            issueInstr({r[31:20], r[4:0], 3'(k), rd, 7'b0010011});
            checkReg(int'(rd), 0);
        end
        issueInstr({7'd1, 5'd2, 5'd1, 3'd5, 5'd20, 7'b0110011}); // odd funct7 adds
        issueInstr({7'h7f, 5'd3, 5'd4, 3'd1, 5'd21, 7'b0110011});
        issueInstr({7'd32, 5'd5, 5'd6, 3'd4, 5'd22, 7'b0110011});
        checkReg(20, 0);
        checkReg(21, 0);
        checkReg(22, 0);
    endtask

    task automatic testBackPressure();
        int waits;
        sendInstr({7'd0, 5'd1, 5'd2, 3'd0, 5'd23, 7'b0110011}, waits);
        checkValue("write wait states", 32'd0, waits);
        checkReg(23, 1);
        sendInstr({7'd32, 5'd3, 5'd4, 3'd0, 5'd24, 7'b0110011}, waits);
        sendInstr({7'd0, 5'd1, 5'd24, 3'd7, 5'd25, 7'b0110011}, waits); // uses x24
        checkValue("write wait states", 32'd1, waits);
        idleCycle();
        checkReg(24, 0);
        checkReg(25, 0);
    endtask

    task automatic testErrors();
        expectError(1'b1, `INSTR_ADDR, {7'd0, 5'd1, 5'd2, 3'd2, 5'd3, 7'b0100011}, "a store");
        expectError(1'b0, `INSTR_ADDR, '0, "a read of the issue register");
        expectError(1'b1, `APB_ADDR_WIDTH'(`REG_BASE + 4), 32'h1234, "a register write");
        expectError(1'b0, 12'h080, '0, "an unmapped address");
        checkAll();
    endtask

    initial begin
        int cycles;
        seed = 23;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        for (int i = 0; i < 32; i++) begin
            regModel[i] = '0;
        end
        cycles = 0;
        while (rstN !== 1'b1) begin
            @(posedge clk);
            cycles++;
            assert (cycles < 10) else stopWithError("reset was never released");
        end
        idleCycle();
        testResetAndLui();
        testRType();
        testIType();
        testBackPressure();
        testErrors();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== tests/tbClock.sv ====
/* Free-running 8 ns clock. rstN is held low for the first 3 rising edges. */
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic rstN
);
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (3) @(posedge clk);
        #1 rstN = 1'b1; // release away from the edge
    end

endmodule
